// File: rv_isa_pkg.sv
package rv_isa_pkg;

    // rv32 data word and register index.
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // jal and jalr write the link value pc + 4 into rd.
    localparam word_t LINK_OFFSET = 32'd4;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'h0,
        ALU_SUB    = 4'h1,
        ALU_SLL    = 4'h2,
        ALU_SLT    = 4'h3,
        ALU_SLTU   = 4'h4,
        ALU_XOR    = 4'h5,
        ALU_SRL    = 4'h6,
        ALU_SRA    = 4'h7,
        ALU_OR     = 4'h8,
        ALU_AND    = 4'h9,
        ALU_PASS_B = 4'hA  // lui.
    } alu_op_e;

    // nine kinds, so the field needs four bits.
    typedef enum logic [3:0] {
        BR_NONE = 4'h0,
        BR_BEQ  = 4'h1,
        BR_BNE  = 4'h2,
        BR_BLT  = 4'h3,
        BR_BGE  = 4'h4,
        BR_BLTU = 4'h5,
        BR_BGEU = 4'h6,
        BR_JAL  = 4'h7,
        BR_JALR = 4'h8
    } branch_type_e;

endpackage

// File: rv_pipe_pkg.sv
package rv_pipe_pkg;

    // operand source picked by the forwarding unit.
    typedef enum logic [1:0] {
        FWD_REG = 2'h0,  // register file value.
        FWD_MEM = 2'h1,  // ex/mem result.
        FWD_WB  = 2'h2   // mem/wb data.
    } fwd_sel_e;

    // what the writeback stage puts into rd.
    typedef enum logic {
        WB_ALU  = 1'b0,
        WB_LOAD = 1'b1
    } wb_src_e;

endpackage

// File: function_unit.sv
`timescale 1ns/1ns

module function_unit import rv_isa_pkg::*; (
    input  word_t   op_a_i,
    input  word_t   op_b_i,
    input  alu_op_e alu_op_i,
    output word_t   result_o,
    output logic    neg_o,
    output logic    zero_o
);

    logic [32:0] diff;
    logic        lt_s;
    logic        lt_u;
    logic [4:0]  shamt;

    assign diff  = {1'b0, op_a_i} - {1'b0, op_b_i};  // bit 32 is the borrow.
    assign lt_u  = diff[32];
    // sign of the true difference, overflow folded in.
    assign lt_s  = (op_a_i[31] != op_b_i[31]) ? op_a_i[31] : diff[31];
    assign shamt = op_b_i[4:0];

    // flags always come from a - b, whatever the op.
    assign neg_o  = lt_s;
    assign zero_o = (diff[31:0] == '0);

    always_comb begin
        case (alu_op_i)
            ALU_ADD: begin
                result_o = op_a_i + op_b_i;
            end
            ALU_SUB: begin
                result_o = diff[31:0];
            end
            ALU_SLL: begin
                result_o = op_a_i << shamt;
            end
            ALU_SLT: begin
                result_o = {31'b0, lt_s};
            end
            ALU_SLTU: begin
                result_o = {31'b0, lt_u};
            end
            ALU_XOR: begin
                result_o = op_a_i ^ op_b_i;
            end
            ALU_SRL: begin
                result_o = op_a_i >> shamt;
            end
            ALU_SRA: begin
                result_o = word_t'($signed(op_a_i) >>> shamt);
            end
            ALU_OR: begin
                result_o = op_a_i | op_b_i;
            end
            ALU_AND: begin
                result_o = op_a_i & op_b_i;
            end
            ALU_PASS_B: begin
                result_o = op_b_i;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// File: branch_resolver.sv
`timescale 1ns/1ns

module branch_resolver import rv_isa_pkg::*; (
    input  logic         clk,
    input  logic         rst_n_i,
    input  branch_type_e branch_type_i,
    input  logic         neg_i,
    input  logic         zero_i,
    input  logic         ltu_i,
    output logic         taken_o,
    output logic         is_jalr_o
);

    always_comb begin
        case (branch_type_i)
            BR_BEQ:  taken_o = zero_i;
            BR_BNE:  taken_o = !zero_i;
            BR_BLT:  taken_o = neg_i;
            BR_BGE:  taken_o = !neg_i;
            BR_BLTU: taken_o = ltu_i;
            BR_BGEU: taken_o = !ltu_i;
            BR_JAL:  taken_o = 1'b1;  // jumps always go.
            BR_JALR: taken_o = 1'b1;
            default: taken_o = 1'b0;
        endcase
    end

    assign is_jalr_o = (branch_type_i == BR_JALR);

    // equal operands are never also less-than.
    a_flags_consistent: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        zero_i |-> !(neg_i || ltu_i)
    ) else $error("zero flag set together with a less-than flag");

endmodule

// File: forwarding_unit.sv
`timescale 1ns/1ns

module forwarding_unit import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    input  logic      ex_mem_valid_i,
    input  reg_addr_t ex_mem_rd_i,
    input  logic      mem_wb_valid_i,
    input  reg_addr_t mem_wb_rd_i,
    output fwd_sel_e  fwd_a_sel_o,
    output fwd_sel_e  fwd_b_sel_o
);

    // a stage can only supply a value it will actually write.
    function automatic logic hit(input logic v, input reg_addr_t rd, input reg_addr_t rs);
        return v && (rd != '0) && (rd == rs);
    endfunction

    function automatic fwd_sel_e pick(input reg_addr_t rs);
        fwd_sel_e sel;
        if (hit(ex_mem_valid_i, ex_mem_rd_i, rs)) begin
            sel = FWD_MEM;  // newest writer wins.
        end else if (hit(mem_wb_valid_i, mem_wb_rd_i, rs)) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_REG;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a_sel_o = pick(rs1_addr_i);
        fwd_b_sel_o = pick(rs2_addr_i);
    end

    // writeback drops x0, so a valid mem/wb slot names a real register.
    a_wb_not_x0: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        mem_wb_valid_i |-> (mem_wb_rd_i != '0)
    ) else $error("mem/wb slot valid with rd x0");

endmodule

// File: execute_stage.sv
`timescale 1ns/1ns

module execute_stage import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         valid_i,
    input  alu_op_e      alu_op_i,
    input  reg_addr_t    rd_addr_i,
    input  word_t        rs1_data_i,
    input  word_t        rs2_data_i,
    input  word_t        imm_i,
    input  logic         use_imm_i,
    input  logic         use_pc_i,
    input  word_t        pc_i,
    input  branch_type_e branch_type_i,
    input  logic         pred_taken_i,
    input  wb_src_e      wb_src_i,
    input  fwd_sel_e     fwd_a_sel_i,
    input  fwd_sel_e     fwd_b_sel_i,
    input  word_t        mem_fwd_data_i,
    input  word_t        wb_fwd_data_i,
    output logic         ex_mem_valid_o,
    output reg_addr_t    ex_mem_rd_o,
    output word_t        ex_mem_result_o,
    output wb_src_e      ex_mem_wb_src_o,
    output logic         redirect_o,
    output word_t        redirect_pc_o
);

    word_t fwd_a;
    word_t fwd_b;
    word_t op_a;
    word_t op_b;
    word_t alu_result;
    word_t cmp_sltu;
    logic  cmp_neg;
    logic  cmp_zero;
    logic  taken;
    logic  is_jalr;
    logic  is_jump;
    word_t pc_plus4;
    word_t target;
    logic  mispredict;

    always_comb begin
        case (fwd_a_sel_i)
            FWD_MEM: fwd_a = mem_fwd_data_i;
            FWD_WB:  fwd_a = wb_fwd_data_i;
            default: fwd_a = rs1_data_i;
        endcase
        case (fwd_b_sel_i)
            FWD_MEM: fwd_b = mem_fwd_data_i;
            FWD_WB:  fwd_b = wb_fwd_data_i;
            default: fwd_b = rs2_data_i;
        endcase
    end

    assign op_a = use_pc_i ? pc_i : fwd_a;  // auipc, jal, branch target.
    assign op_b = use_imm_i ? imm_i : fwd_b;

    function_unit u_alu (
        .op_a_i   (op_a),
        .op_b_i   (op_b),
        .alu_op_i (alu_op_i),
        .result_o (alu_result),
        .neg_o    (),
        .zero_o   ()
    );

    // compare path on the forwarded registers.
    function_unit u_cmp (
        .op_a_i   (fwd_a),
        .op_b_i   (fwd_b),
        .alu_op_i (ALU_SLTU),
        .result_o (cmp_sltu),
        .neg_o    (cmp_neg),
        .zero_o   (cmp_zero)
    );

    branch_resolver u_branch (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .branch_type_i (branch_type_i),
        .neg_i         (cmp_neg),
        .zero_i        (cmp_zero),
        .ltu_i         (|cmp_sltu),
        .taken_o       (taken),
        .is_jalr_o     (is_jalr)
    );

    assign is_jump    = is_jalr || (branch_type_i == BR_JAL);
    assign pc_plus4   = pc_i + LINK_OFFSET;
    assign target     = is_jalr ? {alu_result[31:1], 1'b0} : alu_result;
    assign mispredict = valid_i && (taken != pred_taken_i);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_mem_valid_o <= 1'b0;
            redirect_o     <= 1'b0;
        end else begin
            ex_mem_valid_o <= valid_i;
            redirect_o     <= mispredict;  // one-cycle pulse per slot.
        end
    end

    always_ff @(posedge clk) begin
        ex_mem_rd_o     <= rd_addr_i;
        ex_mem_result_o <= is_jump ? pc_plus4 : alu_result;  // link value.
        ex_mem_wb_src_o <= wb_src_i;
        redirect_pc_o   <= taken ? target : pc_plus4;
    end

    // branch and jal targets add the immediate to the pc.
    a_pc_relative: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (valid_i && !is_jalr && (branch_type_i != BR_NONE)) |-> use_pc_i
    ) else $error("pc-relative target built without the pc");

endmodule

// File: writeback_stage.sv
`timescale 1ns/1ns

module writeback_stage import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      ex_mem_valid_i,
    input  reg_addr_t ex_mem_rd_i,
    input  word_t     ex_mem_result_i,
    input  wb_src_e   ex_mem_wb_src_i,
    input  word_t     load_data_i,
    output logic      wb_valid_o,
    output reg_addr_t wb_rd_o,
    output word_t     wb_data_o
);

    word_t wb_data_d;

    // memory returns load data while the load is in ex/mem.
    always_comb begin
        case (ex_mem_wb_src_i)
            WB_LOAD: wb_data_d = load_data_i;
            default: wb_data_d = ex_mem_result_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= ex_mem_valid_i && (ex_mem_rd_i != '0);  // x0 never written.
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o   <= ex_mem_rd_i;
        wb_data_o <= wb_data_d;
    end

endmodule

// File: ex_pipeline.sv
`timescale 1ns/1ns

module ex_pipeline import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         valid_i,
    input  alu_op_e      alu_op_i,
    input  reg_addr_t    rd_addr_i,
    input  reg_addr_t    rs1_addr_i,
    input  reg_addr_t    rs2_addr_i,
    input  word_t        rs1_data_i,
    input  word_t        rs2_data_i,
    input  word_t        imm_i,
    input  logic         use_imm_i,
    input  logic         use_pc_i,
    input  word_t        pc_i,
    input  branch_type_e branch_type_i,
    input  logic         pred_taken_i,
    input  wb_src_e      wb_src_i,
    input  word_t        load_data_i,
    output logic         wb_valid_o,
    output reg_addr_t    wb_rd_o,
    output word_t        wb_data_o,
    output logic         redirect_o,
    output word_t        redirect_pc_o
);

    fwd_sel_e  fwd_a_sel;
    fwd_sel_e  fwd_b_sel;
    logic      ex_mem_valid;
    reg_addr_t ex_mem_rd;
    word_t     ex_mem_result;
    wb_src_e   ex_mem_wb_src;

    forwarding_unit u_fwd (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .rs1_addr_i     (rs1_addr_i),
        .rs2_addr_i     (rs2_addr_i),
        .ex_mem_valid_i (ex_mem_valid),
        .ex_mem_rd_i    (ex_mem_rd),
        .mem_wb_valid_i (wb_valid_o),
        .mem_wb_rd_i    (wb_rd_o),
        .fwd_a_sel_o    (fwd_a_sel),
        .fwd_b_sel_o    (fwd_b_sel)
    );

    execute_stage u_ex (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .valid_i         (valid_i),
        .alu_op_i        (alu_op_i),
        .rd_addr_i       (rd_addr_i),
        .rs1_data_i      (rs1_data_i),
        .rs2_data_i      (rs2_data_i),
        .imm_i           (imm_i),
        .use_imm_i       (use_imm_i),
        .use_pc_i        (use_pc_i),
        .pc_i            (pc_i),
        .branch_type_i   (branch_type_i),
        .pred_taken_i    (pred_taken_i),
        .wb_src_i        (wb_src_i),
        .fwd_a_sel_i     (fwd_a_sel),
        .fwd_b_sel_i     (fwd_b_sel),
        .mem_fwd_data_i  (ex_mem_result),
        .wb_fwd_data_i   (wb_data_o),
        .ex_mem_valid_o  (ex_mem_valid),
        .ex_mem_rd_o     (ex_mem_rd),
        .ex_mem_result_o (ex_mem_result),
        .ex_mem_wb_src_o (ex_mem_wb_src),
        .redirect_o      (redirect_o),
        .redirect_pc_o   (redirect_pc_o)
    );

    writeback_stage u_wb (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .ex_mem_valid_i  (ex_mem_valid),
        .ex_mem_rd_i     (ex_mem_rd),
        .ex_mem_result_i (ex_mem_result),
        .ex_mem_wb_src_i (ex_mem_wb_src),
        .load_data_i     (load_data_i),
        .wb_valid_o      (wb_valid_o),
        .wb_rd_o         (wb_rd_o),
        .wb_data_o       (wb_data_o)
    );

endmodule

// File: tb_ex_pipeline.sv
`timescale 1ns/1ns

module tb_ex_pipeline import rv_isa_pkg::*, rv_pipe_pkg::*; ();

    localparam int MAX_REC   = 64;
    localparam int MAX_LINES = 256;

    logic         clk;
    logic         rst_n_i;
    logic         valid_i;
    alu_op_e      alu_op_i;
    reg_addr_t    rd_addr_i;
    reg_addr_t    rs1_addr_i;
    reg_addr_t    rs2_addr_i;
    word_t        rs1_data_i;
    word_t        rs2_data_i;
    word_t        imm_i;
    logic         use_imm_i;
    logic         use_pc_i;
    word_t        pc_i;
    branch_type_e branch_type_i;
    logic         pred_taken_i;
    wb_src_e      wb_src_i;
    word_t        load_data_i;
    logic         wb_valid_o;
    reg_addr_t    wb_rd_o;
    word_t        wb_data_o;
    logic         redirect_o;
    word_t        redirect_pc_o;

    logic       v_valid    [MAX_REC];
    logic [3:0] v_op       [MAX_REC];
    reg_addr_t  v_rd       [MAX_REC];
    reg_addr_t  v_rs1      [MAX_REC];
    reg_addr_t  v_rs2      [MAX_REC];
    word_t      v_rs1_data [MAX_REC];  // stale register file values.
    word_t      v_rs2_data [MAX_REC];
    word_t      v_imm      [MAX_REC];
    logic       v_use_imm  [MAX_REC];
    logic       v_use_pc   [MAX_REC];
    word_t      v_pc       [MAX_REC];
    logic [3:0] v_br       [MAX_REC];
    logic       v_pred     [MAX_REC];
    logic       v_wb_src   [MAX_REC];
    word_t      v_load     [MAX_REC];
    logic       e_wb_valid [MAX_REC];
    reg_addr_t  e_wb_rd    [MAX_REC];
    word_t      e_wb_data  [MAX_REC];
    logic       e_redir    [MAX_REC];
    word_t      e_redir_pc [MAX_REC];

    int   n_rec;
    int   errors;
    logic load_ok;

    ex_pipeline UUT (.*);

    always #4 clk = ~clk;

    task automatic read_vectors();
        int    fd;
        int    code;
        int    n_lines;
        string line;
        n_rec   = 0;
        n_lines = 0;
        load_ok = 1'b0;
        fd = $fopen("ex_pipeline_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file ex_pipeline_input.txt");
        end else begin
            while (!$feof(fd) && n_lines < MAX_LINES && n_rec < MAX_REC) begin
                code = $fgets(line, fd);
                n_lines++;
                if (code > 1 && line[0] != "#") begin
                    code = $sscanf(line,
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        v_valid[n_rec], v_op[n_rec], v_rd[n_rec], v_rs1[n_rec],
                        v_rs2[n_rec], v_rs1_data[n_rec], v_rs2_data[n_rec], v_imm[n_rec],
                        v_use_imm[n_rec], v_use_pc[n_rec], v_pc[n_rec], v_br[n_rec],
                        v_pred[n_rec], v_wb_src[n_rec], v_load[n_rec], e_wb_valid[n_rec],
                        e_wb_rd[n_rec], e_wb_data[n_rec], e_redir[n_rec], e_redir_pc[n_rec]);
                    if (code == 20) begin
                        n_rec++;
                    end else begin
                        errors++;
                        $display("malformed vector line %0d: %s", n_lines, line);
                    end
                end
            end
            if (!$feof(fd)) begin
                $display("vector file is longer than the reader accepts");
            end else if (n_rec == 0) begin
                $display("vector file holds no records");
            end else begin
                load_ok = 1'b1;
            end
            $fclose(fd);
        end
    endtask

    // load data belongs to the slot now sitting in ex/mem.
    task automatic drive_slot(input int k);
        if (k < n_rec) begin
            valid_i       = v_valid[k];
            alu_op_i      = alu_op_e'(v_op[k]);
            rd_addr_i     = v_rd[k];
            rs1_addr_i    = v_rs1[k];
            rs2_addr_i    = v_rs2[k];
            rs1_data_i    = v_rs1_data[k];
            rs2_data_i    = v_rs2_data[k];
            imm_i         = v_imm[k];
            use_imm_i     = v_use_imm[k];
            use_pc_i      = v_use_pc[k];
            pc_i          = v_pc[k];
            branch_type_i = branch_type_e'(v_br[k]);
            pred_taken_i  = v_pred[k];
            wb_src_i      = wb_src_e'(v_wb_src[k]);
        end else begin
            valid_i = 1'b0;  // drain.
        end
        if (k >= 1 && k <= n_rec) begin
            load_data_i = v_load[k-1];
        end
    endtask

    // redirect lags one cycle, writeback two.
    task automatic check_outputs(input int j);
        int   w;
        int   r;
        logic exp_valid;
        logic exp_redir;
        w = j - 2;
        r = j - 1;
        exp_valid = 1'b0;
        exp_redir = 1'b0;
        if (w >= 0) begin
            exp_valid = e_wb_valid[w];
        end
        if (r >= 0 && r < n_rec) begin
            exp_redir = e_redir[r];
        end
        if (wb_valid_o !== exp_valid) begin
            errors++;
            $display("[ERROR] %0t ns: wb_valid_o got %b, expected %b",
                $time, wb_valid_o, exp_valid);
        end
        if (exp_valid && wb_rd_o !== e_wb_rd[w]) begin
            errors++;
            $display("[ERROR] %0t ns: wb_rd_o got %0d, expected %0d",
                $time, wb_rd_o, e_wb_rd[w]);
        end
        if (exp_valid && wb_data_o !== e_wb_data[w]) begin
            errors++;
            $display("[ERROR] %0t ns: wb_data_o got %h, expected %h",
                $time, wb_data_o, e_wb_data[w]);
        end
        if (redirect_o !== exp_redir) begin
            errors++;
            $display("[ERROR] %0t ns: redirect_o got %b, expected %b",
                $time, redirect_o, exp_redir);
        end
        if (exp_redir && redirect_pc_o !== e_redir_pc[r]) begin
            errors++;
            $display("[ERROR] %0t ns: redirect_pc_o got %h, expected %h",
                $time, redirect_pc_o, e_redir_pc[r]);
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst_n_i       = 1'b0;
        valid_i       = 1'b0;
        alu_op_i      = ALU_ADD;
        rd_addr_i     = '0;
        rs1_addr_i    = '0;
        rs2_addr_i    = '0;
        rs1_data_i    = '0;
        rs2_data_i    = '0;
        imm_i         = '0;
        use_imm_i     = 1'b0;
        use_pc_i      = 1'b0;
        pc_i          = '0;
        branch_type_i = BR_NONE;
        pred_taken_i  = 1'b0;
        wb_src_i      = WB_ALU;
        load_data_i   = '0;
        errors        = 0;
        read_vectors();
        repeat (4) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        if (load_ok) begin
            for (int j = 0; j < n_rec + 2; j++) begin
                check_outputs(j);
                drive_slot(j);
                @(posedge clk);
                #1;
            end
        end
        $display("records: %0d, errors: %0d", n_rec, errors);
        if (load_ok && errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: ex_pipeline_input.txt
# valid alu_op rd rs1 rs2 rs1_data rs2_data imm use_imm use_pc pc branch pred wb_src load_data
# then expected wb_valid wb_rd wb_data redirect redirect_pc; every field in hex.
1 0 01 02 03 00000011 00000022 00000000 0 0 100 0 0 0 00000000 1 01 00000033 0 000
1 1 04 05 06 00000010 00000030 00000000 0 0 104 0 0 0 00000000 1 04 ffffffe0 0 000
1 2 07 08 09 00000003 00000024 00000000 0 0 108 0 0 0 00000000 1 07 00000030 0 000
1 3 0a 0b 0c ffffffff 00000001 00000000 0 0 10c 0 0 0 00000000 1 0a 00000001 0 000
1 4 0d 0b 0c ffffffff 00000001 00000000 0 0 110 0 0 0 00000000 1 0d 00000000 0 000
1 5 0e 0f 00 f0f0f0f0 00000000 0ff00ff0 1 0 114 0 0 0 00000000 1 0e ff00ff00 0 000
1 6 10 11 00 80000000 00000000 00000008 1 0 118 0 0 0 00000000 1 10 00800000 0 000
1 7 12 11 00 80000000 00000000 00000008 1 0 11c 0 0 0 00000000 1 12 ff800000 0 000
1 8 13 14 15 00ff0000 0000ff00 00000000 0 0 120 0 0 0 00000000 1 13 00ffff00 0 000
1 9 16 14 00 00ff0000 00000000 0ff0f000 1 0 124 0 0 0 00000000 1 16 00f00000 0 000
1 a 17 00 00 00000000 00000000 12345000 1 0 128 0 0 0 00000000 1 17 12345000 0 000
1 0 18 17 00 dead0000 00000000 00000001 1 0 12c 0 0 0 00000000 1 18 12345001 0 000
1 0 19 17 18 bad0bad0 bad0bad0 00000000 0 0 130 0 0 0 00000000 1 19 2468a001 0 000
1 0 1a 00 00 00000000 00000000 00000111 1 0 134 0 0 0 00000000 1 1a 00000111 0 000
1 0 1a 00 00 00000000 00000000 00000222 1 0 138 0 0 0 00000000 1 1a 00000222 0 000
1 0 1b 1a 1a 00005555 00005555 00000000 0 0 13c 0 0 0 00000000 1 1b 00000444 0 000
1 0 00 00 00 00000000 00000000 00000777 1 0 140 0 0 0 00000000 0 00 00000000 0 000
1 0 1c 00 1b 00000000 00009999 00000000 0 0 144 0 0 0 00000000 1 1c 00000444 0 000
1 0 1d 14 00 00ff0000 00000000 00000010 1 0 148 0 0 1 cafef00d 1 1d cafef00d 0 000
0 0 1d 00 00 00000000 00000000 00000040 1 1 14c 7 0 0 00000000 0 00 00000000 0 000
1 0 1f 1d 00 00001234 00000000 00000000 0 0 150 0 0 0 00000000 1 1f cafef00d 0 000
1 0 00 02 03 00000005 00000005 00000040 1 1 154 1 0 0 00000000 0 00 00000000 1 194
1 0 00 02 03 00000005 00000006 00000040 1 1 158 1 0 0 00000000 0 00 00000000 0 000
1 0 00 02 03 00000005 00000006 00000040 1 1 15c 2 1 0 00000000 0 00 00000000 0 000
1 0 00 02 03 00000007 00000007 00000040 1 1 160 2 1 0 00000000 0 00 00000000 1 164
1 0 00 02 03 fffffffe 00000001 fffffff0 1 1 164 3 0 0 00000000 0 00 00000000 1 154
1 0 00 02 03 7fffffff 80000000 00000040 1 1 168 3 1 0 00000000 0 00 00000000 1 16c
1 0 00 02 03 00000003 00000003 00000040 1 1 16c 4 1 0 00000000 0 00 00000000 0 000
1 0 00 02 03 ffffffff 00000000 00000040 1 1 170 4 1 0 00000000 0 00 00000000 1 174
1 0 00 02 03 00000001 ffffffff 00000040 1 1 174 5 0 0 00000000 0 00 00000000 1 1b4
1 0 00 02 03 ffffffff 00000001 00000040 1 1 178 5 0 0 00000000 0 00 00000000 0 000
1 0 00 02 03 ffffffff 00000001 00000040 1 1 17c 6 1 0 00000000 0 00 00000000 0 000
1 0 00 02 03 00000001 00000002 00000040 1 1 180 6 1 0 00000000 0 00 00000000 1 184
1 0 01 00 00 00000000 00000000 00000100 1 1 184 7 0 0 00000000 1 01 00000188 1 284
1 0 05 01 00 0000aaaa 00000000 00000007 1 0 188 8 0 0 00000000 1 05 0000018c 1 18e
1 0 06 00 00 00000000 00000000 00002000 1 1 18c 0 0 0 00000000 1 06 0000218c 0 000
1 0 07 00 00 00000000 00000000 00000020 1 1 190 7 1 0 00000000 1 07 00000194 0 000
1 0 08 02 03 00000001 00000002 00000000 0 0 194 0 1 0 00000000 1 08 00000003 1 198

// File: ex_pipeline.f
rv_isa_pkg.sv
rv_pipe_pkg.sv
function_unit.sv
branch_resolver.sv
forwarding_unit.sv
execute_stage.sv
writeback_stage.sv
ex_pipeline.sv
tb_ex_pipeline.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_ex_pipeline \
    -f ex_pipeline.f -o sim_ex_pipeline
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_ex_pipeline)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1
